//--- hw/zclk_defs.svh
//////////////////////////////
// fixed for a 28 MHz fclk; the phase count and the wait
// length are not meant to be changed on their own
//////////////////////////////
`ifndef ZCLK_DEFS_SVH
`define ZCLK_DEFS_SVH

// fclk cycles per 7 MHz Z80 clock period
`define ZC_PHASES 4

// steps of the 14 MHz IO wait count, which wraps back to idle
`define ZC_IOW_LEN 16

// wishbone register map
`define ZC_REG_TURBO 0
`define ZC_REG_STATUS 1

`endif

//--- hw/zclk_pkg.sv
//////////////////////////////
// turbo code 2'b11 runs at 14 MHz like T140
//////////////////////////////
`default_nettype none

`include "zclk_defs.svh"

package zclk_pkg;

	// requested or active Z80 clock rate
	typedef enum logic [1:0]
	{
		T35  = 2'b00,
		T70  = 2'b01,
		T140 = 2'b10
	} turbo_t;

	// index into the four-phase fclk sequencer
	typedef logic [$clog2(`ZC_PHASES)-1:0] phase_t;

	// upper bit alone selects 14 MHz, so 2'b11 counts too
	function automatic logic is_turbo14(input turbo_t mode);
		return mode[1];
	endfunction

endpackage

`default_nettype wire

//--- hw/wb_pkg.sv
//////////////////////////////
// 8-bit data, two registers
//////////////////////////////
`default_nettype none

`include "zclk_defs.svh"

package wb_pkg;

	// bus data word
	typedef logic [7:0] wb_data_t;

	// register address as it arrives on wb_adr
	typedef logic [0:0] wb_addr_t;

	// named register map, decoded from wb_addr_t
	typedef enum logic [0:0]
	{
		REG_TURBO  = 1'(`ZC_REG_TURBO),
		REG_STATUS = 1'(`ZC_REG_STATUS)
	} reg_addr_e;

endpackage

`default_nettype wire

//--- hw/zclk_regs.sv
//////////////////////////////
// one ack per stb, then waits for stb to drop
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module zclk_regs
(
	input  wire               fclk,
	input  wire               rst_n,
	input  wire               wb_cyc,
	input  wire               wb_stb,
	input  wire               wb_we,
	input  wb_pkg::wb_addr_t  wb_adr,
	input  wb_pkg::wb_data_t  wb_dat_w,
	input  zclk_pkg::turbo_t  int_turbo,
	output wb_pkg::wb_data_t  wb_dat_r,
	output logic              wb_ack,
	output zclk_pkg::turbo_t  turbo_req
);

	import wb_pkg::*;
	import zclk_pkg::*;

	// set after an ack, cleared once the master drops stb
	logic done;
	// new transfer seen this cycle
	logic req;
	reg_addr_e reg_sel;

	assign req     = wb_cyc && wb_stb && !wb_ack && !done;
	assign reg_sel = reg_addr_e'(wb_adr);

	// ack and the end-of-transfer flag
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb_ack <= 1'b0;
			done   <= 1'b0;
		end
		else
		begin
			wb_ack <= req;
			if (wb_ack)
				done <= 1'b1;
			else if (!wb_stb)
				done <= 1'b0;
		end
	end

	// turbo request, only bits 1:0 are kept
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			turbo_req <= T35;
		else if (req && wb_we && reg_sel == REG_TURBO)
			turbo_req <= turbo_t'(wb_dat_w[1:0]);
	end

	// read data is captured with the request and shown during ack
	always_ff @(posedge fclk)
	begin
		if (req && !wb_we)
		begin
			if (reg_sel == REG_STATUS)
				wb_dat_r <= {6'b0, int_turbo};
			else
				wb_dat_r <= {6'b0, turbo_req};
		end
	end

	// ack lasts exactly one cycle
	a_ack_single: assert property (@(posedge fclk) disable iff (!rst_n)
		wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

//--- hw/bus_cycle_decode.sv
//////////////////////////////
// io_start is combinational, valid only while zpos is high
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_decode
(
	input  wire               fclk,
	input  wire               rst_n,
	input  wire               zpos,
	input  wire               rfsh_n,
	input  wire               iorq_n,
	input  wire               m1_n,
	input  wire               external_port,
	input  zclk_pkg::turbo_t  turbo_req,
	output zclk_pkg::turbo_t  int_turbo,
	output logic              io_start
);

	import zclk_pkg::*;

	// rfsh_n as seen at the previous zpos
	logic old_rfsh_n;
	// external IO cycle, not an interrupt ack
	logic io;
	// io as seen at the previous zpos
	logic io_r;

	assign io = !iorq_n && m1_n && external_port;

	// sample bus state on the Z80 rising edge
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			old_rfsh_n <= 1'b1;
			io_r       <= 1'b0;
			int_turbo  <= T35;
		end
		else if (zpos)
		begin
			old_rfsh_n <= rfsh_n;
			io_r       <= io;
			// switch rate only on a falling refresh edge
			if (old_rfsh_n && !rfsh_n)
				int_turbo <= turbo_req;
		end
	end

	// new IO cycle at 14 MHz starts the wait pattern
	assign io_start = zpos && io && !io_r && is_turbo14(int_turbo);

	// the active rate only moves on a Z80 rising edge
	a_turbo_on_zpos: assert property (@(posedge fclk) disable iff (!rst_n)
		!zpos |=> $stable(int_turbo));

endmodule

`default_nettype wire

//--- hw/io_wait_gen.sv
//////////////////////////////
// stall pattern is fixed for a 28 MHz fclk
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "zclk_defs.svh"

module io_wait_gen
(
	input  wire   fclk,
	input  wire   rst_n,
	input  wire   io_start,
	input  wire   zclk_stall,
	output logic  stall
);

	localparam int CW = $clog2(`ZC_IOW_LEN);

	// zero means idle, otherwise steps once per fclk
	logic [CW-1:0] wait_cnt;
	// registered decode of the count
	logic io_wait;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			wait_cnt <= '0;
		else if (io_start)
			wait_cnt <= CW'(1);
		else if (wait_cnt != '0)
			// wraps to zero after the last step
			wait_cnt <= wait_cnt + CW'(1);
	end

	// 1..12 stall, 13 runs, 14 stalls, 15 runs
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_wait <= 1'b0;
		else
		begin
			case (wait_cnt)
				CW'(0):  io_wait <= 1'b0;
				CW'(13): io_wait <= 1'b0;
				CW'(15): io_wait <= 1'b0;
				default: io_wait <= 1'b1;
			endcase
		end
	end

	assign stall = zclk_stall || io_wait;

	// a fresh IO cycle never lands inside a running wait
	a_no_restart: assert property (@(posedge fclk) disable iff (!rst_n)
		io_start |-> wait_cnt == '0);

endmodule

`default_nettype wire

//--- hw/zclk_phase_gen.sv
//////////////////////////////
// zclk_out changes on falling fclk, half a cycle after the strobe
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "zclk_defs.svh"

module zclk_phase_gen
(
	input  wire               fclk,
	input  wire               rst_n,
	input  wire               stall,
	input  zclk_pkg::turbo_t  int_turbo,
	output logic              zpos,
	output logic              zneg,
	output logic              zclk_out
);

	import zclk_pkg::*;

	// free-running four-phase sequencer
	phase_t phase;
	logic c0;
	logic c2;
	// picks every other c2 for 3.5 MHz
	logic half_c2;
	// 14 MHz source, holds while stalled
	logic clk14_src;
	// strobe sources before gating
	logic pre_zpos;
	logic pre_zneg;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			phase <= '0;
		else if (phase == phase_t'(`ZC_PHASES - 1))
			phase <= '0;
		else
			phase <= phase + phase_t'(1);
	end

	assign c0 = (phase == phase_t'(0));
	assign c2 = (phase == phase_t'(`ZC_PHASES / 2));

	// toggles on each c2
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			half_c2 <= 1'b0;
		else if (c2)
			half_c2 <= !half_c2;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			clk14_src <= 1'b0;
		else if (!stall)
			clk14_src <= !clk14_src;
	end

	// source select by active rate
	always_comb
	begin
		case (int_turbo)
			T35:
			begin
				// zpos and zneg alternate on c2
				pre_zpos = c2 && !half_c2;
				pre_zneg = c2 && half_c2;
			end
			T70:
			begin
				pre_zpos = c2;
				pre_zneg = c0;
			end
			default:
			begin
				// T140 and the spare code 2'b11
				pre_zpos = clk14_src;
				pre_zneg = !clk14_src;
			end
		endcase
	end

	// a strobe only fires when it really moves zclk_out
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= !stall && pre_zpos && zclk_out;
			zneg <= !stall && pre_zneg && !zclk_out;
		end
	end

	// Z80 clock, leads the next fclk rising edge by half a cycle
	always_ff @(negedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			zclk_out <= 1'b1;
		else if (zpos)
			zclk_out <= 1'b0;
		else if (zneg)
			zclk_out <= 1'b1;
	end

	a_strobe_excl: assert property (@(posedge fclk) disable iff (!rst_n)
		!(zpos && zneg));

endmodule

`default_nettype wire

//--- hw/zclock_top.sv
//////////////////////////////
// Z80 core, arbiter and DRAM lie outside
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module zclock_top
(
	input  wire               fclk,
	input  wire               rst_n,
	// wishbone slave
	input  wire               wb_cyc,
	input  wire               wb_stb,
	input  wire               wb_we,
	input  wb_pkg::wb_addr_t  wb_adr,
	input  wb_pkg::wb_data_t  wb_dat_w,
	output wb_pkg::wb_data_t  wb_dat_r,
	output logic              wb_ack,
	// Z80 bus state
	input  wire               rfsh_n,
	input  wire               iorq_n,
	input  wire               m1_n,
	input  wire               external_port,
	input  wire               zclk_stall,
	// clock outputs
	output logic              zpos,
	output logic              zneg,
	output logic              zclk_out
);

	import zclk_pkg::*;

	turbo_t turbo_req;
	turbo_t int_turbo;
	logic io_start;
	logic stall;

	zclk_regs u_regs
	(
		.fclk      (fclk),
		.rst_n     (rst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.int_turbo (int_turbo),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.turbo_req (turbo_req)
	);

	bus_cycle_decode u_decode
	(
		.fclk          (fclk),
		.rst_n         (rst_n),
		.zpos          (zpos),
		.rfsh_n        (rfsh_n),
		.iorq_n        (iorq_n),
		.m1_n          (m1_n),
		.external_port (external_port),
		.turbo_req     (turbo_req),
		.int_turbo     (int_turbo),
		.io_start      (io_start)
	);

	io_wait_gen u_wait
	(
		.fclk       (fclk),
		.rst_n      (rst_n),
		.io_start   (io_start),
		.zclk_stall (zclk_stall),
		.stall      (stall)
	);

	zclk_phase_gen u_phase
	(
		.fclk      (fclk),
		.rst_n     (rst_n),
		.stall     (stall),
		.int_turbo (int_turbo),
		.zpos      (zpos),
		.zneg      (zneg),
		.zclk_out  (zclk_out)
	);

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
//////////////////////////////
// reset is released between clock edges
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
#(
	parameter int PERIOD     = 100,
	parameter int RST_CYCLES = 3
)
(
	output logic fclk,
	output logic rst_n
);

	initial
	begin
		fclk = 1'b0;
		forever
			#(PERIOD / 2) fclk = !fclk;
	end

	// reset held over the first rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES)
			@(posedge fclk);
		#(PERIOD / 4) rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- verif/tb_zclock.sv
//////////////////////////////
// directed tests at a 100 ns fclk
// inputs move 10 ns after the rising edge
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "zclk_defs.svh"

module tb_zclock;

	import zclk_pkg::*;
	import wb_pkg::*;

	localparam int PERIOD = 100;
	localparam int DRIVE_DLY = 10;
	localparam int SEED = 32'h06ac656e;
	// cycle budget per test
	localparam int LEN_REGS = 200;
	localparam int LEN_REFRESH = 400;
	localparam int LEN_RATES = 1200;
	localparam int LEN_STALL = 200;
	localparam int LEN_IO = 1000;
	localparam int LEN_TOTAL = LEN_REGS + LEN_REFRESH + LEN_RATES + LEN_STALL + LEN_IO;
	localparam int LEN_MARGIN = 500;
	// counts 1 to 12 of the IO wait hold the strobes
	localparam int IO_STALL = 12;
	localparam wb_addr_t TURBO_ADR = wb_addr_t'(`ZC_REG_TURBO);
	localparam wb_addr_t STATUS_ADR = wb_addr_t'(`ZC_REG_STATUS);

	logic fclk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic wb_ack;
	logic rfsh_n;
	logic iorq_n;
	logic m1_n;
	logic external_port;
	logic zclk_stall;
	logic zpos;
	logic zneg;
	logic zclk_out;

	int errors;

	tb_clkgen #(.PERIOD(PERIOD), .RST_CYCLES(3)) u_clk
	(
		.fclk  (fclk),
		.rst_n (rst_n)
	);

	zclock_top dut
	(
		.fclk          (fclk),
		.rst_n         (rst_n),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.rfsh_n        (rfsh_n),
		.iorq_n        (iorq_n),
		.m1_n          (m1_n),
		.external_port (external_port),
		.zclk_stall    (zclk_stall),
		.zpos          (zpos),
		.zneg          (zneg),
		.zclk_out      (zclk_out)
	);

	// one fclk step, ends at the drive point where outputs are stable
	task automatic tick();
		@(posedge fclk);
		#DRIVE_DLY;
	endtask

	task automatic check_turbo(input string name, input turbo_t exp, input turbo_t act);
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s: expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
		begin
			errors++;
			$display("[ERROR] %s: expected %0d actual %0d", name, exp, act);
		end
	endtask

	// single classic cycle, holds stb until ack
	task automatic wb_transfer(input logic we, input wb_addr_t adr, input wb_data_t wdata,
		output wb_data_t rdata);
		int n;
		n = 0;
		rdata = '0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		do
		begin
			tick();
			n++;
		end
		while (!wb_ack && n < 16);
		if (wb_ack)
			rdata = wb_dat_r;
		else
		begin
			errors++;
			$display("wishbone access to address %0d got no ack within 16 cycles", adr);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// slave needs stb low for two edges before the next request
		repeat (2)
			tick();
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
		wb_data_t unused;
		wb_transfer(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
		wb_transfer(1'b0, adr, 8'h00, data);
	endtask

	task automatic check_status(input string name, input turbo_t exp);
		wb_data_t d;
		wb_read(STATUS_ADR, d);
		check_turbo(name, exp, turbo_t'(d[1:0]));
	endtask

	task automatic wait_zpos(input string name);
		int n;
		n = 0;
		do
		begin
			tick();
			n++;
		end
		while (!zpos && n < 32);
		if (!zpos)
		begin
			errors++;
			$display("%s: no zpos seen within 32 fclk cycles", name);
		end
	endtask

	// rfsh_n high at one zpos, low at the next
	task automatic refresh_pulse(input string name);
		wait_zpos(name);
		tick();
		rfsh_n = 1'b0;
		wait_zpos(name);
		tick();
		rfsh_n = 1'b1;
	endtask

	task automatic set_mode(input string name, input turbo_t mode);
		wb_write(TURBO_ADR, {6'b0, mode});
		refresh_pulse(name);
		check_status(name, mode);
		// let the strobes fall into the new rhythm
		repeat (16)
			tick();
	endtask

	task automatic test_regs();
		wb_data_t d;
		wb_read(STATUS_ADR, d);
		check_data("regs_reset", 8'h00, d);
		check_turbo("regs_reset", T35, turbo_t'(d[1:0]));
		// only bits 1:0 are kept
		wb_write(TURBO_ADR, 8'hfd);
		wb_read(TURBO_ADR, d);
		check_data("regs_readback", 8'h01, d);
		check_status("regs_status_hold", T35);
	endtask

	task automatic test_refresh();
		int dly;
		dly = $urandom_range(20, 1);
		repeat (dly)
			tick();
		check_status("refresh_before", T35);
		refresh_pulse("refresh_edge");
		check_status("refresh_edge", T70);
		// new request, no refresh edge
		wb_write(TURBO_ADR, {6'b0, T140});
		dly = $urandom_range(20, 1);
		repeat (dly)
			tick();
		check_status("refresh_none", T70);
	endtask

	// zpos spacing, zneg midway, zclk_out level after each strobe
	task automatic test_rate(input string name, input turbo_t mode, input int gap);
		int cyc;
		int last_pos;
		int npos;
		logic was_pos;
		logic was_neg;
		set_mode(name, mode);
		cyc = 0;
		last_pos = -1;
		npos = 0;
		was_pos = 1'b0;
		was_neg = 1'b0;
		while (npos < 6 && cyc < 8 * gap)
		begin
			tick();
			cyc++;
			if (was_pos)
				check_count({name, "_low_after_zpos"}, 0, int'(zclk_out));
			if (was_neg)
				check_count({name, "_high_after_zneg"}, 1, int'(zclk_out));
			was_pos = zpos;
			was_neg = zneg;
			if (zneg && last_pos >= 0)
				check_count({name, "_zneg_offset"}, gap / 2, cyc - last_pos);
			if (zpos)
			begin
				if (last_pos >= 0)
					check_count({name, "_zpos_gap"}, gap, cyc - last_pos);
				last_pos = cyc;
				npos++;
			end
		end
		check_count({name, "_zpos_pulses"}, 6, npos);
	endtask

	task automatic test_stall(input string name, input int period);
		int hold;
		int n;
		logic resumed;
		hold = $urandom_range(20, 5);
		wait_zpos(name);
		zclk_stall = 1'b1;
		repeat (hold)
		begin
			tick();
			check_count({name, "_strobe_in_hold"}, 0, int'(zpos || zneg));
		end
		zclk_stall = 1'b0;
		resumed = 1'b0;
		for (n = 0; n < period && !resumed; n++)
		begin
			tick();
			if (zpos || zneg)
				resumed = 1'b1;
		end
		if (!resumed)
		begin
			errors++;
			$display("%s: strobes did not resume within %0d cycles of release", name, period);
		end
	endtask

	// longest run of cycles with neither strobe after an IO cycle begins
	task automatic test_io(input string name, input logic m1, input logic ext, input int exp_run);
		int n;
		int run;
		int longest;
		wait_zpos(name);
		tick();
		m1_n = m1;
		external_port = ext;
		iorq_n = 1'b0;
		run = 0;
		longest = 0;
		for (n = 0; n < 30; n++)
		begin
			tick();
			if (zpos || zneg)
				run = 0;
			else
			begin
				run++;
				if (run > longest)
					longest = run;
			end
		end
		check_count({name, "_longest_gap"}, exp_run, longest);
		iorq_n = 1'b1;
		m1_n = 1'b1;
		external_port = 1'b0;
		// two zpos clear the sampled io state
		wait_zpos(name);
		wait_zpos(name);
	endtask

	initial
	begin
		errors = 0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		rfsh_n = 1'b1;
		iorq_n = 1'b1;
		m1_n = 1'b1;
		external_port = 1'b0;
		zclk_stall = 1'b0;
		void'($urandom(SEED));
		wait (rst_n === 1'b1);
		tick();
		test_regs();
		test_refresh();
		test_rate("rate_t35", T35, 8);
		test_rate("rate_t70", T70, 4);
		test_rate("rate_t140", T140, 2);
		test_stall("stall_t140", 2);
		test_io("io_t140", 1'b1, 1'b1, IO_STALL);
		// at 14 MHz a strobe falls in every cycle
		test_io("io_no_ext", 1'b1, 1'b0, 0);
		test_io("io_m1", 1'b0, 1'b1, 0);
		set_mode("io_mode_t70", T70);
		test_io("io_t70", 1'b1, 1'b1, 1);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// watchdog over the summed test budgets
	initial
	begin
		#(PERIOD * (LEN_TOTAL + LEN_MARGIN));
		$display("watchdog expired after %0d fclk cycles, the tests hung",
			LEN_TOTAL + LEN_MARGIN);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/zclk_pkg.sv
hw/wb_pkg.sv
hw/zclk_regs.sv
hw/bus_cycle_decode.sv
hw/io_wait_gen.sv
hw/zclk_phase_gen.sv
hw/zclock_top.sv
verif/tb_clkgen.sv
verif/tb_zclock.sv

//--- Bender.yml
package:
  name: zclock

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/zclk_pkg.sv
      - hw/wb_pkg.sv
      - hw/zclk_regs.sv
      - hw/bus_cycle_decode.sv
      - hw/io_wait_gen.sv
      - hw/zclk_phase_gen.sv
      - hw/zclock_top.sv
  - target: simulation
    files:
      - verif/tb_clkgen.sv
      - verif/tb_zclock.sv
